//--- rtl/stm_pkg.sv
package stm_pkg;

  localparam int NUM_TRANS = 4;
  localparam int TRANS_W = $clog2(NUM_TRANS);
  localparam int MEM_DEPTH = 256;           // entries per segment
  localparam int MEM_AW = 9;                // segment bit + 8 index bits
  localparam int DIST_SQ_W = 34;
  localparam int ROOT_W = 17;               // floor sqrt of a DIST_SQ_W value

  localparam logic MODE_GAIN = 1'b0;
  localparam logic MODE_FOCUS = 1'b1;

  localparam logic [15:0] REP_INFINITE = 16'hffff;

  // transducer i at x = i * pitch, y = z = 0
  localparam int TRANS_PITCH = 100;

  typedef union packed {
    struct packed {
      logic [NUM_TRANS-1:0][15:0] slot;     // {intensity, phase}, slot 0 lowest
    } gain;
    struct packed {
      logic [7:0] rsvd;
      logic [7:0] intensity;
      logic signed [15:0] z;
      logic signed [15:0] y;
      logic signed [15:0] x;
    } focus;
  } pattern_word_t;

endpackage

//--- rtl/stm_mem.sv
module stm_mem
  import stm_pkg::*;
(
  input  logic              CLK,
  input  logic              wr_en,
  input  logic [MEM_AW-1:0] wr_addr,
  input  pattern_word_t     wr_data,
  input  logic [MEM_AW-1:0] rd_addr,
  output pattern_word_t     rd_data
);

  // segment 0 in the lower half, segment 1 in the upper
  pattern_word_t mem [2*MEM_DEPTH];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- rtl/stm_timer.sv
module stm_timer (
  input  logic        CLK,
  input  logic        rst,
  input  logic [15:0] cycle_0,
  input  logic [15:0] freq_div_0,
  input  logic [15:0] cycle_1,
  input  logic [15:0] freq_div_1,
  output logic [15:0] idx_0,
  output logic [15:0] idx_1,
  output logic        wrap_0,
  output logic        wrap_1
);

  logic [15:0] cyc [2];
  logic [15:0] div [2];

  assign cyc[0] = cycle_0;
  assign cyc[1] = cycle_1;
  assign div[0] = freq_div_0;
  assign div[1] = freq_div_1;

  for (genvar g = 0; g < 2; g++) begin : g_seg
    logic [15:0] cnt;
    logic [15:0] idx_q;
    logic        wrap_q;
    logic        tick;

    assign tick = cnt >= div[g] - 16'd1;  // prescaler terminal count

    always_ff @(posedge CLK) begin
      if (rst) begin
        cnt <= '0;
        idx_q <= '0;
        wrap_q <= 1'b0;
      end else begin
        wrap_q <= 1'b0;
        if (tick) begin
          cnt <= '0;
          // >= so a shrunk cycle still wraps at the next step
          if (idx_q >= cyc[g] - 16'd1) begin
            idx_q <= '0;
            wrap_q <= 1'b1;
          end else begin
            idx_q <= idx_q + 16'd1;
          end
        end else begin
          cnt <= cnt + 16'd1;
        end
      end
    end

    // a step never lands on the cycle value it was taken against
    a_idx_below_cycle: assert property (
      @(posedge CLK) disable iff (rst) tick |=> idx_q != $past(cyc[g]));
  end

  assign idx_0 = g_seg[0].idx_q;
  assign idx_1 = g_seg[1].idx_q;
  assign wrap_0 = g_seg[0].wrap_q;
  assign wrap_1 = g_seg[1].wrap_q;

endmodule

//--- rtl/stm_swapchain.sv
module stm_swapchain
  import stm_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  logic        update_settings,
  input  logic        req_mode,
  input  logic        req_segment,
  input  logic [15:0] rep,
  input  logic        wrap_0,
  input  logic        wrap_1,
  output logic        mode,
  output logic        segment,
  output logic        stop
);

  logic        pend;
  logic        pend_mode;
  logic        pend_seg;
  logic [15:0] pend_rep;
  logic [15:0] rep_cnt;
  logic        active_wrap;

  assign active_wrap = segment ? wrap_1 : wrap_0;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= 1'b0;
      mode <= MODE_GAIN;
      segment <= 1'b0;
      stop <= 1'b0;
      rep_cnt <= REP_INFINITE;              // free running until first request
    end else begin
      if (active_wrap) begin
        if (pend) begin
          mode <= pend_mode;
          segment <= pend_seg;
          rep_cnt <= pend_rep;
          stop <= 1'b0;
          pend <= 1'b0;
        end else if (rep_cnt != REP_INFINITE) begin
          if (rep_cnt == '0) begin
            stop <= 1'b1;
          end else begin
            rep_cnt <= rep_cnt - 16'd1;
          end
        end
      end
      // a request landing on a wrap waits for the next one
      if (update_settings) begin
        pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (update_settings) begin
      pend_mode <= req_mode;
      pend_seg <= req_segment;
      pend_rep <= rep;
    end
  end

endmodule

//--- rtl/stm_gain.sv
module stm_gain
  import stm_pkg::*;
(
  input  logic          CLK,
  input  logic          rst,
  input  logic          start,
  input  pattern_word_t word,
  output logic [7:0]    intensity,
  output logic [7:0]    phase,
  output logic          dout_valid
);

  logic [NUM_TRANS-1:0][15:0] slots;
  logic [TRANS_W-1:0]         left;         // slots still to emit after this one

  always_ff @(posedge CLK) begin
    if (rst) begin
      dout_valid <= 1'b0;
      left <= '0;
    end else if (start) begin
      dout_valid <= 1'b1;
      left <= TRANS_W'(NUM_TRANS - 1);
    end else if (left != '0) begin
      dout_valid <= 1'b1;
      left <= left - 1'b1;
    end else begin
      dout_valid <= 1'b0;
    end
  end

  // transducer 0 goes out with start, the rest shift down
  always_ff @(posedge CLK) begin
    if (start) begin
      intensity <= word.gain.slot[0][15:8];
      phase <= word.gain.slot[0][7:0];
      slots <= word.gain.slot >> 16;
    end else if (left != '0) begin
      intensity <= slots[0][15:8];
      phase <= slots[0][7:0];
      slots <= slots >> 16;
    end
  end

endmodule

//--- rtl/stm_focus.sv
module stm_focus
  import stm_pkg::*;
(
  input  logic          CLK,
  input  logic          rst,
  input  logic          start,
  input  pattern_word_t word,
  input  logic [15:0]   sound_speed,
  output logic [7:0]    intensity,
  output logic [7:0]    phase,
  output logic          dout_valid
);

  logic                        busy;
  logic                        load;        // distance load cycle for current transducer
  logic [TRANS_W-1:0]          tr;
  logic [4:0]                  iter;
  logic signed [15:0]          fx;
  logic signed [15:0]          fy;
  logic signed [15:0]          fz;
  logic [7:0]                  fint;
  logic [9:0]                  tx;
  logic signed [DIST_SQ_W-1:0] dx;
  logic [DIST_SQ_W-1:0]        dsq;
  logic [DIST_SQ_W-1:0]        rad;
  logic [ROOT_W:0]             rem;
  logic [ROOT_W-1:0]           root;
  logic [ROOT_W-1:0]           root_nx;
  logic [ROOT_W+2:0]           rem_sh;
  logic [ROOT_W+2:0]           trial;
  logic [ROOT_W+2:0]           rem_nx;
  logic                        ge;
  logic [ROOT_W+15:0]          prod;

  assign tx = 10'(tr) * 10'(TRANS_PITCH);
  assign dx = $signed({1'b0, tx}) - fx;
  assign dsq = dx * dx + fy * fy + fz * fz;

  // one root bit per cycle, two radicand bits in
  assign rem_sh = {rem, rad[DIST_SQ_W-1 -: 2]};
  assign trial = {1'b0, root, 2'b01};
  assign ge = rem_sh >= trial;
  assign rem_nx = ge ? rem_sh - trial : rem_sh;
  assign root_nx = {root[ROOT_W-2:0], ge};
  assign prod = root_nx * sound_speed;

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy <= 1'b0;
      load <= 1'b0;
      tr <= '0;
      iter <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        load <= 1'b1;
        tr <= '0;
      end else if (busy && load) begin
        load <= 1'b0;
        iter <= 5'(ROOT_W - 1);
      end else if (busy) begin
        if (iter == '0) begin
          dout_valid <= 1'b1;
          if (tr == TRANS_W'(NUM_TRANS - 1)) begin
            busy <= 1'b0;                   // frame done
          end else begin
            tr <= tr + 1'b1;
            load <= 1'b1;
          end
        end else begin
          iter <= iter - 5'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      fx <= word.focus.x;
      fy <= word.focus.y;
      fz <= word.focus.z;
      fint <= word.focus.intensity;
    end
    if (busy && load) begin
      rad <= dsq;
      rem <= '0;
      root <= '0;
    end else if (busy) begin
      rad <= rad << 2;
      rem <= rem_nx[ROOT_W:0];
      root <= root_nx;
    end
    if (busy && !load && iter == '0) begin
      phase <= prod[15:8];
      intensity <= fint;
    end
  end

  // updates must be spaced beyond a whole focus frame
  a_start_idle: assert property (@(posedge CLK) disable iff (rst) start |-> !busy);

endmodule

//--- rtl/stm.sv
module stm
  import stm_pkg::*;
(
  input  logic              CLK,
  input  logic              rst,
  input  logic              update,
  input  logic              update_settings,
  input  logic              req_mode,
  input  logic              req_segment,
  input  logic [15:0]       rep,
  input  logic [15:0]       cycle_0,
  input  logic [15:0]       freq_div_0,
  input  logic [15:0]       cycle_1,
  input  logic [15:0]       freq_div_1,
  input  logic [15:0]       sound_speed,
  output logic [MEM_AW-1:0] rd_addr,
  input  pattern_word_t     rd_data,
  output logic [7:0]        intensity,
  output logic [7:0]        phase,
  output logic              dout_valid,
  output logic [15:0]       debug_idx,
  output logic              debug_segment,
  output logic              stop
);

  logic [15:0] idx_0;
  logic [15:0] idx_1;
  logic        wrap_0;
  logic        wrap_1;
  logic        sw_mode;
  logic        sw_seg;
  logic [15:0] sw_idx;
  logic        mode_q;
  logic        seg_q;
  logic [15:0] idx_q;
  logic        start;
  logic        take;
  logic [7:0]  gain_int;
  logic [7:0]  gain_ph;
  logic        gain_vld;
  logic [7:0]  focus_int;
  logic [7:0]  focus_ph;
  logic        focus_vld;

  stm_timer u_timer (
    .CLK(CLK), .rst(rst),
    .cycle_0(cycle_0), .freq_div_0(freq_div_0),
    .cycle_1(cycle_1), .freq_div_1(freq_div_1),
    .idx_0(idx_0), .idx_1(idx_1), .wrap_0(wrap_0), .wrap_1(wrap_1)
  );

  stm_swapchain u_swapchain (
    .CLK(CLK), .rst(rst), .update_settings(update_settings),
    .req_mode(req_mode), .req_segment(req_segment), .rep(rep),
    .wrap_0(wrap_0), .wrap_1(wrap_1),
    .mode(sw_mode), .segment(sw_seg), .stop(stop)
  );

  assign sw_idx = sw_seg ? idx_1 : idx_0;
  assign take = update && !stop;

  always_ff @(posedge CLK) begin
    if (rst) begin
      mode_q <= MODE_GAIN;
      seg_q <= 1'b0;
      idx_q <= '0;
      start <= 1'b0;
    end else begin
      start <= update;                      // stopped frames replay the held index
      if (take) begin
        mode_q <= sw_mode;
        seg_q <= sw_seg;
        idx_q <= sw_idx;
      end
    end
  end

  // memory read register lines up with start
  assign rd_addr = take ? {sw_seg, sw_idx[MEM_AW-2:0]} : {seg_q, idx_q[MEM_AW-2:0]};

  stm_gain u_gain (
    .CLK(CLK), .rst(rst), .start(start && mode_q == MODE_GAIN), .word(rd_data),
    .intensity(gain_int), .phase(gain_ph), .dout_valid(gain_vld)
  );

  stm_focus u_focus (
    .CLK(CLK), .rst(rst), .start(start && mode_q == MODE_FOCUS), .word(rd_data),
    .sound_speed(sound_speed),
    .intensity(focus_int), .phase(focus_ph), .dout_valid(focus_vld)
  );

  assign intensity = mode_q == MODE_GAIN ? gain_int : focus_int;
  assign phase = mode_q == MODE_GAIN ? gain_ph : focus_ph;
  assign dout_valid = mode_q == MODE_GAIN ? gain_vld : focus_vld;
  assign debug_idx = idx_q;
  assign debug_segment = seg_q;

  // frame latch and settings handoff must not share an edge
  a_update_exclusive: assert property (
    @(posedge CLK) disable iff (rst) !(update && update_settings));

endmodule

//--- rtl/stm_top.sv
module stm_top
  import stm_pkg::*;
(
  input  logic              CLK,
  input  logic              rst,
  input  logic              wr_en,
  input  logic [MEM_AW-1:0] wr_addr,
  input  pattern_word_t     wr_data,
  input  logic              update,
  input  logic              update_settings,
  input  logic              req_mode,
  input  logic              req_segment,
  input  logic [15:0]       rep,
  input  logic [15:0]       cycle_0,
  input  logic [15:0]       freq_div_0,
  input  logic [15:0]       cycle_1,
  input  logic [15:0]       freq_div_1,
  input  logic [15:0]       sound_speed,
  output logic [7:0]        intensity,
  output logic [7:0]        phase,
  output logic              dout_valid,
  output logic [15:0]       debug_idx,
  output logic              debug_segment,
  output logic              stop
);

  logic [MEM_AW-1:0] rd_addr;
  pattern_word_t     rd_data;

  stm_mem u_mem (
    .CLK(CLK),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  stm u_stm (
    .CLK(CLK),
    .rst(rst),
    .update(update),
    .update_settings(update_settings),
    .req_mode(req_mode),
    .req_segment(req_segment),
    .rep(rep),
    .cycle_0(cycle_0),
    .freq_div_0(freq_div_0),
    .cycle_1(cycle_1),
    .freq_div_1(freq_div_1),
    .sound_speed(sound_speed),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .intensity(intensity),
    .phase(phase),
    .dout_valid(dout_valid),
    .debug_idx(debug_idx),
    .debug_segment(debug_segment),
    .stop(stop)
  );

endmodule

//--- dv/stm_tb.sv
module stm_tb
  import stm_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 5;
  localparam int FRAME_CYCLES = 96;         // longer than a whole focus frame
  localparam int N_GAIN = 24;
  localparam int N_FOCUS = 12;
  localparam int N_SWAP = 24;
  localparam int N_UPDATES = N_GAIN + N_FOCUS + N_SWAP;
  localparam int SETUP_CYCLES = 3000;

  logic              CLK = 1'b0;
  logic              rst;
  logic              wr_en;
  logic [MEM_AW-1:0] wr_addr;
  pattern_word_t     wr_data;
  logic              update;
  logic              update_settings;
  logic              req_mode;
  logic              req_segment;
  logic [15:0]       rep;
  logic [15:0]       cycle_0;
  logic [15:0]       freq_div_0;
  logic [15:0]       cycle_1;
  logic [15:0]       freq_div_1;
  logic [15:0]       sound_speed;
  logic [7:0]        intensity;
  logic [7:0]        phase;
  logic              dout_valid;
  logic [15:0]       debug_idx;
  logic              debug_segment;
  logic              stop;

  // reference model state
  pattern_word_t m_mem [2*MEM_DEPTH];
  int            m_cnt [2];
  int            m_idx [2];
  logic          m_wrap [2];
  logic          m_pend;
  logic          m_pend_mode;
  logic          m_pend_seg;
  logic [15:0]   m_pend_rep;
  logic          m_mode;
  logic          m_seg;
  logic          m_stop;
  logic [15:0]   m_rep_cnt;
  logic          m_mode_q;
  logic          m_seg_q;
  logic [15:0]   m_idx_q;

  logic [31:0]   lfsr_state;
  int            checks = 0;
  int            errors = 0;
  int            stop_seen = 0;

  stm_top UUT (
    .CLK(CLK), .rst(rst),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .update(update), .update_settings(update_settings),
    .req_mode(req_mode), .req_segment(req_segment), .rep(rep),
    .cycle_0(cycle_0), .freq_div_0(freq_div_0),
    .cycle_1(cycle_1), .freq_div_1(freq_div_1), .sound_speed(sound_speed),
    .intensity(intensity), .phase(phase), .dout_valid(dout_valid),
    .debug_idx(debug_idx), .debug_segment(debug_segment), .stop(stop)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;     // taps 32 22 2 1
    end
    return s >> 1;
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // largest r with r*r <= d, one trial bit at a time from the top
  function automatic longint int_sqrt(longint d);
    longint r;
    longint b;
    r = 0;
    for (int i = 17; i >= 0; i--) begin
      b = longint'(1) << i;
      if ((r + b) * (r + b) <= d) begin
        r = r + b;
      end
    end
    return r;
  endfunction

  function automatic logic [7:0] focus_phase(pattern_word_t w, int t, logic [15:0] ss);
    longint dx;
    longint dy;
    longint dz;
    longint root;
    dx = longint'(t * TRANS_PITCH) - longint'(w.focus.x);
    dy = longint'(w.focus.y);
    dz = longint'(w.focus.z);
    root = int_sqrt(dx * dx + dy * dy + dz * dz);
    return 8'((root * longint'(ss)) >> 8);
  endfunction

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic reset_model();
    for (int s = 0; s < 2; s++) begin
      m_cnt[s] = 0;
      m_idx[s] = 0;
      m_wrap[s] = 1'b0;
    end
    m_pend = 1'b0;
    m_mode = MODE_GAIN;
    m_seg = 1'b0;
    m_stop = 1'b0;
    m_rep_cnt = REP_INFINITE;             // no stop before the first request
    m_mode_q = MODE_GAIN;
    m_seg_q = 1'b0;
    m_idx_q = '0;
  endtask

  // what the DUT does at the coming rising edge, from the inputs now driven
  task automatic step_model();
    logic aw;
    int   cyc;
    int   div;
    aw = m_seg ? m_wrap[1] : m_wrap[0];
    if (update && !m_stop) begin
      m_mode_q = m_mode;
      m_seg_q = m_seg;
      m_idx_q = 16'(m_idx[m_seg]);
    end
    if (aw && m_pend) begin
      m_mode = m_pend_mode;
      m_seg = m_pend_seg;
      m_rep_cnt = m_pend_rep;
      m_stop = 1'b0;
      m_pend = 1'b0;
    end else if (aw && m_rep_cnt != REP_INFINITE) begin
      if (m_rep_cnt == 16'd0) begin
        m_stop = 1'b1;
      end else begin
        m_rep_cnt = m_rep_cnt - 16'd1;
      end
    end
    if (update_settings) begin
      m_pend = 1'b1;
      m_pend_mode = req_mode;
      m_pend_seg = req_segment;
      m_pend_rep = rep;
    end
    for (int s = 0; s < 2; s++) begin
      cyc = (s == 0) ? int'(cycle_0) : int'(cycle_1);
      div = (s == 0) ? int'(freq_div_0) : int'(freq_div_1);
      m_wrap[s] = 1'b0;
      if (m_cnt[s] + 1 >= div) begin
        m_cnt[s] = 0;
        if (m_idx[s] + 1 >= cyc) begin
          m_idx[s] = 0;
          m_wrap[s] = 1'b1;
        end else begin
          m_idx[s]++;
        end
      end else begin
        m_cnt[s]++;
      end
    end
    if (wr_en) begin
      m_mem[wr_addr] = wr_data;
    end
  endtask

  task automatic advance_cycle();
    step_model();
    @(negedge CLK);
    update = 1'b0;                        // strobes last one cycle
    update_settings = 1'b0;
    wr_en = 1'b0;
    check_value("stop", 64'(m_stop), 64'(stop));
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge CLK);
    reset_model();
    rst = 1'b0;
    check_value("dout_valid", 64'(1'b0), 64'(dout_valid));
    check_value("stop", 64'(1'b0), 64'(stop));
    check_value("debug_idx", 64'(16'd0), 64'(debug_idx));
    check_value("debug_segment", 64'(1'b0), 64'(debug_segment));
  endtask

  task automatic pick_timing(int cyc_bits, int div_bits);
    cycle_0 = 16'(rand_bits(cyc_bits)) + 16'd1;
    freq_div_0 = 16'(rand_bits(div_bits)) + 16'd1;
    cycle_1 = 16'(rand_bits(cyc_bits)) + 16'd1;
    freq_div_1 = 16'(rand_bits(div_bits)) + 16'd1;
  endtask

  task automatic fill_memory();
    for (int a = 0; a < 2 * MEM_DEPTH; a++) begin
      wr_en = 1'b1;
      wr_addr = MEM_AW'(a);
      wr_data = rand_bits(64);
      advance_cycle();
    end
  endtask

  task automatic send_settings(logic mode, logic seg, logic [15:0] r);
    update_settings = 1'b1;
    req_mode = mode;
    req_segment = seg;
    rep = r;
    advance_cycle();
  endtask

  task automatic wait_for_swap();
    int n;
    n = 0;
    while (m_pend && n < 4096) begin
      advance_cycle();
      n++;
    end
    checks++;
    assert (!m_pend) else begin
      errors++;
      $display("settings request was never applied at a segment wrap");
    end
  endtask

  task automatic run_frame(int n);
    logic [7:0]    exp_int [NUM_TRANS];
    logic [7:0]    exp_ph [NUM_TRANS];
    pattern_word_t w;
    int            pulses;
    sound_speed = 16'(rand_bits(16));
    update = 1'b1;
    advance_cycle();
    check_value("debug_idx", 64'(m_idx_q), 64'(debug_idx));
    check_value("debug_segment", 64'(m_seg_q), 64'(debug_segment));
    w = m_mem[{m_seg_q, m_idx_q[7:0]}];
    for (int t = 0; t < NUM_TRANS; t++) begin
      if (m_mode_q == MODE_GAIN) begin
        exp_int[t] = w.gain.slot[t][15:8];
        exp_ph[t] = w.gain.slot[t][7:0];
      end else begin
        exp_int[t] = w.focus.intensity;
        exp_ph[t] = focus_phase(w, t, sound_speed);
      end
    end
    pulses = 0;
    for (int k = 2; k <= FRAME_CYCLES; k++) begin
      advance_cycle();
      if (dout_valid) begin
        if (pulses == 0 && m_mode_q == MODE_GAIN) begin
          checks++;
          assert (k == 2) else begin
            errors++;
            $display("frame %0d: first gain output came %0d cycles after update, not 2",
                     n, k);
          end
        end
        if (pulses < NUM_TRANS) begin
          check_value("intensity", 64'(exp_int[pulses]), 64'(intensity));
          check_value("phase", 64'(exp_ph[pulses]), 64'(phase));
        end
        pulses++;
      end
    end
    checks++;
    assert (pulses == NUM_TRANS) else begin
      errors++;
      $display("frame %0d gave %0d output pulses instead of %0d", n, pulses, NUM_TRANS);
    end
  endtask

  initial begin
    rst = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    update = 1'b0;
    update_settings = 1'b0;
    req_mode = MODE_GAIN;
    req_segment = 1'b0;
    rep = REP_INFINITE;
    cycle_0 = 16'd1;
    freq_div_0 = 16'd1;
    cycle_1 = 16'd1;
    freq_div_1 = 16'd1;
    sound_speed = '0;
    lfsr_state = 32'd95700;

    // gain frames, long loops
    pick_timing(8, 3);
    apply_reset();
    fill_memory();
    for (int n = 0; n < N_GAIN; n++) begin
      if (n == N_GAIN / 2) begin
        send_settings(MODE_GAIN, 1'b1, REP_INFINITE);
      end
      run_frame(n);
    end

    // focus frames
    pick_timing(6, 2);
    apply_reset();
    send_settings(MODE_FOCUS, 1'(rand_bits(1)), REP_INFINITE);
    wait_for_swap();
    for (int n = 0; n < N_FOCUS; n++) begin
      run_frame(N_GAIN + n);
    end

    // short loops so swaps and stop happen within a few frames
    pick_timing(4, 2);
    apply_reset();
    send_settings(1'(rand_bits(1)), 1'(rand_bits(1)), 16'(rand_bits(2)));
    for (int n = 0; n < N_SWAP; n++) begin
      if (n == N_SWAP / 2) begin
        checks++;
        assert (stop_seen > 0) else begin
          errors++;
          $display("stop never rose with a finite repetition count");
        end
        send_settings(1'(rand_bits(1)), 1'(rand_bits(1)), REP_INFINITE);
        wait_for_swap();
      end
      run_frame(N_GAIN + N_FOCUS + n);
      if (stop) begin
        stop_seen++;
      end
    end
    check_value("stop", 64'(1'b0), 64'(stop));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_UPDATES * 100 + SETUP_CYCLES) * CLK_PERIOD);
    $display("timeout, the run did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb.f
rtl/stm_pkg.sv
rtl/stm_mem.sv
rtl/stm_timer.sv
rtl/stm_swapchain.sv
rtl/stm_gain.sv
rtl/stm_focus.sv
rtl/stm.sv
rtl/stm_top.sv
dv/stm_tb.sv

//--- Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = stm_tb
FLIST  = tb.f

BUILD  = obj_dir
BIN    = $(BUILD)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
